// File: filelist.f
+incdir+include
source/hdd_bus_pkg.sv
source/hdd_disk_pkg.sv
source/hdd_task_regs.sv
source/hdd_byte_stream.sv
source/hdd_sector_buffer.sv
source/hdd_top.sv
tests/hdd_tb.sv

// File: tests/hdd_tb.sv
// Testbench for the hard-disk controller: clock, bus tasks, LFSR data, assertions, reporting
`default_nettype none

`include "hdd_defs.svh"

module hdd_tb import hdd_bus_pkg::*, hdd_disk_pkg::*; ();

    localparam int CLK_PERIOD  = 100;
    localparam int DRIVE_DELAY = 10;
    // Two 512-byte streams at four clocks per access plus the short tests come to about
    // 5000 clocks, the limit leaves room for several times that
    localparam int CYCLE_LIMIT = 20000;

    // DUT inputs
    logic        CLK_14M;
    logic        RESET;
    logic        phi0;
    logic        DEVICE_SELECT;
    logic [15:0] A;
    logic        RD;
    bus_byte_t   D_IN;
    unit_mask_t  hdd_mounted;
    unit_mask_t  hdd_protect;
    sec_offset_t ram_addr;
    bus_byte_t   ram_di;
    logic        ram_we;

    // DUT outputs
    bus_byte_t   D_OUT;
    block_num_t  sector;
    logic        hdd_read;
    logic        hdd_write;
    logic        hdd_unit;
    bus_byte_t   ram_do;

    // Run bookkeeping
    int          cycles       = 0;
    int          read_pulses  = 0;
    int          write_pulses = 0;
    int          total_errors = 0;
    int          test_errors  = 0;
    int          tests_run    = 0;
    int          tests_failed = 0;
    string       test_name    = "startup";
    logic [31:0] lfsr_state;
    // Expected sector contents
    bus_byte_t   sector_data [0:`HDD_SECTOR_BYTES-1];

    hdd_top DUT (
        .CLK_14M       (CLK_14M),
        .RESET         (RESET),
        .phi0          (phi0),
        .DEVICE_SELECT (DEVICE_SELECT),
        .A             (A),
        .RD            (RD),
        .D_IN          (D_IN),
        .D_OUT         (D_OUT),
        .sector        (sector),
        .hdd_read      (hdd_read),
        .hdd_write     (hdd_write),
        .hdd_unit      (hdd_unit),
        .hdd_mounted   (hdd_mounted),
        .hdd_protect   (hdd_protect),
        .ram_addr      (ram_addr),
        .ram_di        (ram_di),
        .ram_do        (ram_do),
        .ram_we        (ram_we)
    );

    initial begin
        CLK_14M = 1'b0;
        forever #(CLK_PERIOD / 2) CLK_14M = ~CLK_14M;
    end

    // ------------------------------------------------------------
    // Reporting helpers
    // ------------------------------------------------------------
    task automatic note_failure(input string msg);
        $display("ERROR in %s: %s", test_name, msg);
        total_errors++;
        test_errors++;
    endtask

    task automatic check_value(input string what, input logic [15:0] expected,
                               input logic [15:0] actual);
        assert (actual === expected) else begin
            $display("FAILED %s: %s expected %h actual %h", test_name, what, expected, actual);
            total_errors++;
            test_errors++;
        end
    endtask

    task automatic start_test(input string name);
        test_name   = name;
        test_errors = 0;
    endtask

    task automatic finish_test();
        tests_run++;
        if (test_errors == 0) begin
            $display("PASS %s", test_name);
        end else begin
            tests_failed++;
            $display("FAIL %s, %0d errors", test_name, test_errors);
        end
    endtask

    // Clock counter, strobe pulse counters and timeout
    always @(posedge CLK_14M) begin
        cycles = cycles + 1;
        if (hdd_read) begin
            read_pulses = read_pulses + 1;
        end
        if (hdd_write) begin
            write_pulses = write_pulses + 1;
        end
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: run stopped after %0d clocks in %s", cycles, test_name);
            $display("Simulation failed");
            $finish;
        end
    end

    // ------------------------------------------------------------
    // Bus protocol checks
    // ------------------------------------------------------------
    read_strobe_width: assert property (@(posedge CLK_14M) disable iff (RESET)
        hdd_read |=> !hdd_read)
        else note_failure("hdd_read stayed high for two clocks");

    write_strobe_width: assert property (@(posedge CLK_14M) disable iff (RESET)
        hdd_write |=> !hdd_write)
        else note_failure("hdd_write stayed high for two clocks");

    // Data bus idles unless the cycle before was a read access
    bus_idle: assert property (@(posedge CLK_14M) disable iff (RESET)
        !$past(DEVICE_SELECT && phi0 && RD) |-> (D_OUT == `HDD_BUS_IDLE))
        else note_failure("D_OUT was not idle after a cycle without a read access");

    // ------------------------------------------------------------
    // Stimulus helpers
    // ------------------------------------------------------------
    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        logic feedback;
        feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
        return {state[30:0], feedback};
    endfunction

    task automatic random_byte(output bus_byte_t value);
        value = '0;
        for (int b = 0; b < 8; b++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value = {value[6:0], lfsr_state[0]};
        end
    endtask

    task automatic wait_drive();
        @(posedge CLK_14M);
        #DRIVE_DELAY;
    endtask

    // One access clock, then three idle clocks
    task automatic bus_write(input reg_offset_t offset, input bus_byte_t data);
        A             = {12'hC0F, offset};
        D_IN          = data;
        RD            = 1'b0;
        DEVICE_SELECT = 1'b1;
        phi0          = 1'b1;
        wait_drive();
        DEVICE_SELECT = 1'b0;
        phi0          = 1'b0;
        repeat (3) wait_drive();
    endtask

    task automatic bus_read(input reg_offset_t offset, output bus_byte_t data);
        A             = {12'hC0F, offset};
        RD            = 1'b1;
        DEVICE_SELECT = 1'b1;
        phi0          = 1'b1;
        wait_drive();
        DEVICE_SELECT = 1'b0;
        phi0          = 1'b0;
        RD            = 1'b0;
        // Read data is held for the clock after the access
        data          = D_OUT;
        repeat (3) wait_drive();
    endtask

    task automatic expect_read(input reg_offset_t offset, input bus_byte_t expected,
                               input string what);
        bus_byte_t got;
        bus_read(offset, got);
        check_value(what, expected, got);
    endtask

    // ------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------
    initial begin
        bus_byte_t reg_data [0:8];
        lfsr_state    = 32'hd08a00ec;
        RESET         = 1'b1;
        phi0          = 1'b0;
        DEVICE_SELECT = 1'b0;
        A             = '0;
        RD            = 1'b0;
        D_IN          = '0;
        hdd_mounted   = 2'b00;
        hdd_protect   = 2'b00;
        ram_addr      = '0;
        ram_di        = '0;
        ram_we        = 1'b0;
        repeat (3) @(posedge CLK_14M);
        #DRIVE_DELAY;
        RESET = 1'b0;

        start_test("reset");
        check_value("hdd_read", 1'b0, hdd_read);
        check_value("hdd_write", 1'b0, hdd_write);
        check_value("D_OUT", `HDD_BUS_IDLE, D_OUT);
        for (int off = 1; off <= 7; off++) begin
            expect_read(reg_offset_t'(off), 8'h00, $sformatf("offset %0d", off));
        end
        finish_test();

        start_test("register file");
        for (int off = 2; off <= 7; off++) begin
            random_byte(reg_data[off]);
            bus_write(reg_offset_t'(off), reg_data[off]);
        end
        for (int off = 2; off <= 7; off++) begin
            expect_read(reg_offset_t'(off), reg_data[off], $sformatf("offset %0d", off));
        end
        check_value("sector", {reg_data[`HDD_REG_BLOCK_H], reg_data[`HDD_REG_BLOCK_L]}, sector);
        check_value("hdd_unit", reg_data[`HDD_REG_UNIT][7], hdd_unit);
        finish_test();

        start_test("status command");
        hdd_mounted = 2'b01;
        bus_write(`HDD_REG_COMMAND, `HDD_CMD_STATUS);
        bus_write(`HDD_REG_UNIT, 8'h00);
        expect_read(`HDD_REG_EXEC, `HDD_STATUS_OK, "unit 0 execute");
        expect_read(`HDD_REG_STATUS, `HDD_STATUS_OK, "unit 0 status");
        bus_write(`HDD_REG_UNIT, 8'h80);
        expect_read(`HDD_REG_EXEC, `HDD_STATUS_ERROR, "unit 1 execute");
        expect_read(`HDD_REG_STATUS, `HDD_STATUS_ERROR, "unit 1 status");
        finish_test();

        start_test("read command");
        // Host fills the sector over the DMA port
        for (int i = 0; i < `HDD_SECTOR_BYTES; i++) begin
            random_byte(sector_data[i]);
            ram_addr = sec_offset_t'(i);
            ram_di   = sector_data[i];
            ram_we   = 1'b1;
            wait_drive();
        end
        ram_we = 1'b0;
        bus_write(`HDD_REG_UNIT, 8'h00);
        bus_write(`HDD_REG_COMMAND, `HDD_CMD_READ);
        expect_read(`HDD_REG_STATUS, `HDD_STATUS_BUSY, "status after command");
        read_pulses = 0;
        expect_read(`HDD_REG_EXEC, `HDD_STATUS_BUSY, "execute");
        check_value("hdd_read pulses", 16'd1, read_pulses);
        for (int i = 0; i < `HDD_SECTOR_BYTES; i++) begin
            expect_read(`HDD_REG_NEXT_BYTE, sector_data[i], $sformatf("byte %0d", i));
        end
        expect_read(`HDD_REG_STATUS, `HDD_STATUS_OK, "status after last byte");
        // Unmounted unit
        hdd_mounted = 2'b00;
        bus_write(`HDD_REG_COMMAND, `HDD_CMD_READ);
        read_pulses = 0;
        expect_read(`HDD_REG_EXEC, `HDD_STATUS_ERROR, "execute unmounted");
        check_value("hdd_read pulses unmounted", 16'd0, read_pulses);
        finish_test();

        start_test("write command");
        hdd_mounted = 2'b11;
        hdd_protect = 2'b10;
        bus_write(`HDD_REG_UNIT, 8'h80);
        bus_write(`HDD_REG_COMMAND, `HDD_CMD_WRITE);
        write_pulses = 0;
        expect_read(`HDD_REG_EXEC, `HDD_STATUS_PROTECT, "execute protected");
        check_value("hdd_write pulses protected", 16'd0, write_pulses);
        expect_read(`HDD_REG_STATUS, `HDD_STATUS_ERROR, "status after protected");
        bus_write(`HDD_REG_UNIT, 8'h00);
        bus_write(`HDD_REG_COMMAND, `HDD_CMD_WRITE);
        write_pulses = 0;
        expect_read(`HDD_REG_EXEC, `HDD_STATUS_BUSY, "execute");
        check_value("hdd_write pulses", 16'd1, write_pulses);
        for (int i = 0; i < `HDD_SECTOR_BYTES; i++) begin
            random_byte(sector_data[i]);
            bus_write(`HDD_REG_NEXT_BYTE, sector_data[i]);
        end
        // ram_do trails ram_addr by two clocks
        for (int i = 0; i < `HDD_SECTOR_BYTES + 2; i++) begin
            if (i >= 2) begin
                check_value($sformatf("ram_do at %0d", i - 2), sector_data[i - 2], ram_do);
            end
            if (i < `HDD_SECTOR_BYTES) begin
                ram_addr = sec_offset_t'(i);
            end
            wait_drive();
        end
        finish_test();

        $display("Tests run %0d, failed %0d, check errors %0d",
                 tests_run, tests_failed, total_errors);
        if (total_errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: source/hdd_top.sv
// Top level of the ProDOS hard-disk controller: task registers, byte stream, sector RAM
`default_nettype none

module hdd_top import hdd_bus_pkg::*, hdd_disk_pkg::*; (
    // Apple II bus side
    input  wire          CLK_14M,
    input  wire          RESET,
    input  wire          phi0,
    input  wire          DEVICE_SELECT,
    input  wire  [15:0]  A,
    input  wire          RD,
    input  wire          bus_byte_t D_IN,
    output bus_byte_t    D_OUT,
    // Host side
    output block_num_t   sector,
    output logic         hdd_read,
    output logic         hdd_write,
    output logic         hdd_unit,
    input  wire          unit_mask_t hdd_mounted,
    input  wire          unit_mask_t hdd_protect,
    input  wire          sec_offset_t ram_addr,
    input  wire          bus_byte_t ram_di,
    output bus_byte_t    ram_do,
    input  wire          ram_we
);

    // Register select from the low address nibble
    reg_offset_t addr;

    // Task registers to byte stream
    logic        stream_start_read;
    logic        stream_start_write;
    logic        stream_step_read;
    logic        stream_step_write;
    bus_byte_t   stream_din;
    bus_byte_t   next_byte;
    logic        last_byte;

    // Byte stream to sector RAM
    sec_offset_t cpu_addr;
    logic        cpu_we;
    bus_byte_t   cpu_din;
    bus_byte_t   cpu_q;

    assign addr = A[3:0];

    // ------------------------------------------------------------
    // Bus decode and registers
    // ------------------------------------------------------------
    hdd_task_regs u_task_regs (
        .CLK_14M            (CLK_14M),
        .RESET              (RESET),
        .phi0               (phi0),
        .DEVICE_SELECT      (DEVICE_SELECT),
        .RD                 (RD),
        .addr               (addr),
        .D_IN               (D_IN),
        .hdd_mounted        (hdd_mounted),
        .hdd_protect        (hdd_protect),
        .next_byte          (next_byte),
        .last_byte          (last_byte),
        .D_OUT              (D_OUT),
        .sector             (sector),
        .hdd_unit           (hdd_unit),
        .hdd_read           (hdd_read),
        .hdd_write          (hdd_write),
        .stream_start_read  (stream_start_read),
        .stream_start_write (stream_start_write),
        .stream_step_read   (stream_step_read),
        .stream_step_write  (stream_step_write),
        .stream_din         (stream_din)
    );

    // Pointer and staging for offset 8
    hdd_byte_stream u_byte_stream (
        .CLK_14M            (CLK_14M),
        .RESET              (RESET),
        .stream_start_read  (stream_start_read),
        .stream_start_write (stream_start_write),
        .stream_step_read   (stream_step_read),
        .stream_step_write  (stream_step_write),
        .stream_din         (stream_din),
        .cpu_q              (cpu_q),
        .cpu_addr           (cpu_addr),
        .cpu_we             (cpu_we),
        .cpu_din            (cpu_din),
        .next_byte          (next_byte),
        .last_byte          (last_byte)
    );

    // Host DMA on port A, CPU stream on port B
    hdd_sector_buffer u_sector_buffer (
        .CLK_14M  (CLK_14M),
        .dma_addr (ram_addr),
        .dma_din  (ram_di),
        .dma_we   (ram_we),
        .cpu_addr (cpu_addr),
        .cpu_din  (cpu_din),
        .cpu_we   (cpu_we),
        .dma_dout (ram_do),
        .cpu_q    (cpu_q)
    );

endmodule

`default_nettype wire

// File: source/hdd_sector_buffer.sv
// 512x8 true dual-port sector RAM with registered DMA readback
`default_nettype none

`include "hdd_defs.svh"

module hdd_sector_buffer import hdd_bus_pkg::*, hdd_disk_pkg::*; (
    input  wire         CLK_14M,
    input  wire         sec_offset_t dma_addr,
    input  wire         bus_byte_t dma_din,
    input  wire         dma_we,
    input  wire         sec_offset_t cpu_addr,
    input  wire         bus_byte_t cpu_din,
    input  wire         cpu_we,
    output bus_byte_t   dma_dout,
    output bus_byte_t   cpu_q
);

    // Sector storage
    bus_byte_t mem [0:`HDD_SECTOR_BYTES-1];

    // Raw port A read before the output stage
    bus_byte_t dma_q;

    // ------------------------------------------------------------
    // Port A, host DMA
    // ------------------------------------------------------------
    always @(posedge CLK_14M) begin
        if (dma_we) begin
            mem[dma_addr] <= dma_din;
        end
        dma_q <= mem[dma_addr];
    end

    // Extra stage gives the two-clock ram_do latency
    always_ff @(posedge CLK_14M) begin
        dma_dout <= dma_q;
    end

    // ------------------------------------------------------------
    // Port B, CPU byte stream
    // ------------------------------------------------------------
    always @(posedge CLK_14M) begin
        if (cpu_we) begin
            mem[cpu_addr] <= cpu_din;
        end
        cpu_q <= mem[cpu_addr];
    end

endmodule

`default_nettype wire

// File: source/hdd_byte_stream.sv
// Sector pointer, CPU-port write staging and next-byte staging
`default_nettype none

`include "hdd_defs.svh"

module hdd_byte_stream import hdd_bus_pkg::*, hdd_disk_pkg::*; (
    input  wire          CLK_14M,
    input  wire          RESET,
    input  wire          stream_start_read,
    input  wire          stream_start_write,
    input  wire          stream_step_read,
    input  wire          stream_step_write,
    input  wire          bus_byte_t stream_din,
    input  wire          bus_byte_t cpu_q,
    output sec_offset_t  cpu_addr,
    output logic         cpu_we,
    output bus_byte_t    cpu_din,
    output bus_byte_t    next_byte,
    output logic         last_byte
);

    // Byte position of the next CPU transfer
    sec_offset_t ptr;
    // Offset captured with a staged write
    sec_offset_t wr_addr;

    // Pointer sitting on the final byte of the sector
    assign last_byte = (ptr == sec_offset_t'(`HDD_SECTOR_BYTES - 1));

    // Staged write owns the port for one clock, pointer otherwise
    assign cpu_addr = cpu_we ? wr_addr : ptr;

    // ------------------------------------------------------------
    // Pointer and write enable
    // ------------------------------------------------------------
    always_ff @(posedge CLK_14M) begin
        if (RESET) begin
            ptr    <= '0;
            cpu_we <= 1'b0;
        end else begin
            cpu_we <= stream_step_write;
            // New command restarts at offset 0
            if (stream_start_read || stream_start_write) begin
                ptr <= '0;
            end else if (stream_step_read || stream_step_write) begin
                ptr <= ptr + 1'b1;
            end
        end
    end

    // ------------------------------------------------------------
    // Data staging
    // ------------------------------------------------------------
    always_ff @(posedge CLK_14M) begin
        // Two clocks from pointer change to a valid next byte
        next_byte <= cpu_q;
        if (stream_step_write) begin
            wr_addr <= ptr;
            cpu_din <= stream_din;
        end
    end

endmodule

`default_nettype wire

// File: source/hdd_task_regs.sv
// Bus decode, task registers, command execution, status register and read-data mux
`default_nettype none

`include "hdd_defs.svh"

module hdd_task_regs import hdd_bus_pkg::*, hdd_disk_pkg::*; (
    input  wire         CLK_14M,
    input  wire         RESET,
    input  wire         phi0,
    input  wire         DEVICE_SELECT,
    input  wire         RD,
    input  wire         reg_offset_t addr,
    input  wire         bus_byte_t D_IN,
    input  wire         unit_mask_t hdd_mounted,
    input  wire         unit_mask_t hdd_protect,
    input  wire         bus_byte_t next_byte,
    input  wire         last_byte,
    output bus_byte_t   D_OUT,
    output block_num_t  sector,
    output logic        hdd_unit,
    output logic        hdd_read,
    output logic        hdd_write,
    output logic        stream_start_read,
    output logic        stream_start_write,
    output logic        stream_step_read,
    output logic        stream_step_write,
    output bus_byte_t   stream_din
);

    // Task registers
    prodos_cmd_t    cmd_reg;
    prodos_status_t status_reg;
    bus_byte_t      unit_reg;
    bus_byte_t      mem_l_reg;
    bus_byte_t      mem_h_reg;
    bus_byte_t      block_l_reg;
    bus_byte_t      block_h_reg;

    // Access qualification
    logic access;
    logic rd_access;
    logic wr_access;
    logic cmd_wr;
    logic rw_cmd;

    // Per-unit flags for the selected drive
    logic unit_mounted;
    logic unit_protect;

    // Result of executing the stored command
    bus_byte_t      exec_dout;
    prodos_status_t exec_status;
    logic           exec_status_we;
    logic           exec_read;
    logic           exec_write;

    // ------------------------------------------------------------
    // Decode
    // ------------------------------------------------------------

    // One clock with both select and phase 0 high is one access
    assign access    = DEVICE_SELECT & phi0;
    assign rd_access = access & RD;
    assign wr_access = access & ~RD;

    assign cmd_wr = wr_access && (addr == `HDD_REG_COMMAND);
    assign rw_cmd = (D_IN == `HDD_CMD_READ) || (D_IN == `HDD_CMD_WRITE);

    // Host-facing block number and drive select
    assign sector   = {block_h_reg, block_l_reg};
    assign hdd_unit = unit_reg[7];

    assign unit_mounted = hdd_mounted[hdd_unit];
    assign unit_protect = hdd_protect[hdd_unit];

    // Stream control, pulsed in the access cycle itself
    assign stream_start_read  = cmd_wr && (D_IN == `HDD_CMD_READ);
    assign stream_start_write = cmd_wr && (D_IN == `HDD_CMD_WRITE);
    assign stream_step_read   = rd_access && (addr == `HDD_REG_NEXT_BYTE);
    assign stream_step_write  = wr_access && (addr == `HDD_REG_NEXT_BYTE);
    assign stream_din         = D_IN;

    // ------------------------------------------------------------
    // Command execution on a read of offset 0
    // ------------------------------------------------------------
    always_comb begin
        exec_dout      = status_reg;
        exec_status    = status_reg;
        exec_status_we = 1'b0;
        exec_read      = 1'b0;
        exec_write     = 1'b0;
        case (cmd_reg)
            `HDD_CMD_STATUS: begin
                // Report mounted as OK, otherwise error
                exec_status_we = 1'b1;
                exec_status    = unit_mounted ? `HDD_STATUS_OK : `HDD_STATUS_ERROR;
                exec_dout      = unit_mounted ? `HDD_STATUS_OK : `HDD_STATUS_ERROR;
            end
            `HDD_CMD_READ: begin
                if (unit_mounted) begin
                    // Status stays BUSY from the command write
                    exec_read = 1'b1;
                end else begin
                    exec_status_we = 1'b1;
                    exec_status    = `HDD_STATUS_ERROR;
                    exec_dout      = `HDD_STATUS_ERROR;
                end
            end
            `HDD_CMD_WRITE: begin
                // Protection wins over the mounted check
                if (unit_protect) begin
                    exec_status_we = 1'b1;
                    exec_status    = `HDD_STATUS_ERROR;
                    exec_dout      = `HDD_STATUS_PROTECT;
                end else if (unit_mounted) begin
                    exec_write = 1'b1;
                end else begin
                    exec_status_we = 1'b1;
                    exec_status    = `HDD_STATUS_ERROR;
                    exec_dout      = `HDD_STATUS_ERROR;
                end
            end
            // Unknown command, status returned as is
            default: begin
                exec_dout = status_reg;
            end
        endcase
    end

    // ------------------------------------------------------------
    // Register file, strobes and read data
    // ------------------------------------------------------------
    always_ff @(posedge CLK_14M) begin
        if (RESET) begin
            cmd_reg     <= '0;
            status_reg  <= '0;
            unit_reg    <= '0;
            mem_l_reg   <= '0;
            mem_h_reg   <= '0;
            block_l_reg <= '0;
            block_h_reg <= '0;
            hdd_read    <= 1'b0;
            hdd_write   <= 1'b0;
            D_OUT       <= `HDD_BUS_IDLE;
        end else begin
            // Bus idles and strobes drop unless an access says otherwise
            D_OUT     <= `HDD_BUS_IDLE;
            hdd_read  <= 1'b0;
            hdd_write <= 1'b0;

            if (wr_access) begin
                case (addr)
                    `HDD_REG_COMMAND: begin
                        cmd_reg    <= D_IN;
                        status_reg <= rw_cmd ? `HDD_STATUS_BUSY : `HDD_STATUS_OK;
                    end
                    `HDD_REG_UNIT:    unit_reg    <= D_IN;
                    `HDD_REG_MEM_L:   mem_l_reg   <= D_IN;
                    `HDD_REG_MEM_H:   mem_h_reg   <= D_IN;
                    `HDD_REG_BLOCK_L: block_l_reg <= D_IN;
                    `HDD_REG_BLOCK_H: block_h_reg <= D_IN;
                    // Execute and status ignore writes, next byte goes to the stream
                    default: ;
                endcase
            end

            if (rd_access) begin
                case (addr)
                    `HDD_REG_EXEC: begin
                        D_OUT     <= exec_dout;
                        hdd_read  <= exec_read;
                        hdd_write <= exec_write;
                        if (exec_status_we) begin
                            status_reg <= exec_status;
                        end
                    end
                    `HDD_REG_STATUS:  D_OUT <= status_reg;
                    `HDD_REG_COMMAND: D_OUT <= cmd_reg;
                    `HDD_REG_UNIT:    D_OUT <= unit_reg;
                    `HDD_REG_MEM_L:   D_OUT <= mem_l_reg;
                    `HDD_REG_MEM_H:   D_OUT <= mem_h_reg;
                    `HDD_REG_BLOCK_L: D_OUT <= block_l_reg;
                    `HDD_REG_BLOCK_H: D_OUT <= block_h_reg;
                    `HDD_REG_NEXT_BYTE: begin
                        D_OUT <= next_byte;
                        // Last byte of the sector ends the transfer
                        if (last_byte) begin
                            status_reg <= `HDD_STATUS_OK;
                        end
                    end
                    default: ;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// File: source/hdd_disk_pkg.sv
// Disk side types: block number, sector offset, command, status and unit flags
`default_nettype none

`include "hdd_defs.svh"

package hdd_disk_pkg;

    // ProDOS block number, 16 bits wide
    typedef logic [15:0] block_num_t;

    // Byte position inside the 512-byte sector buffer
    typedef logic [`HDD_SECTOR_AW-1:0] sec_offset_t;

    // Command byte as written to the command register
    typedef logic [7:0] prodos_cmd_t;

    // Status byte returned by execute and the status register
    typedef logic [7:0] prodos_status_t;

    // One flag per drive, index is unit bit 7
    typedef logic [1:0] unit_mask_t;

endpackage

`default_nettype wire

// File: source/hdd_bus_pkg.sv
// CPU bus types: data byte and register offset
`default_nettype none

package hdd_bus_pkg;

    // ------------------------------------------------------------
    // Apple II CPU side
    // ------------------------------------------------------------

    // One byte on the 6502 data bus
    typedef logic [7:0] bus_byte_t;

    // Register select, low nibble of the address bus
    typedef logic [3:0] reg_offset_t;

endpackage

`default_nettype wire

// File: include/hdd_defs.svh
// Task register offsets, ProDOS command and status codes, sector geometry, idle bus value
`ifndef HDD_DEFS_SVH
`define HDD_DEFS_SVH

// ------------------------------------------------------------
// Task register offsets, taken from address bits 3..0
// ------------------------------------------------------------

// Read executes the stored command and returns its status
`define HDD_REG_EXEC        4'h0
// Status or error code, read only
`define HDD_REG_STATUS      4'h1
`define HDD_REG_COMMAND     4'h2
// Bit 7 selects the drive
`define HDD_REG_UNIT        4'h3
// Memory buffer address, kept as plain storage
`define HDD_REG_MEM_L       4'h4
`define HDD_REG_MEM_H       4'h5
// Block number presented to the host
`define HDD_REG_BLOCK_L     4'h6
`define HDD_REG_BLOCK_H     4'h7
// Streams the sector buffer one byte per access
`define HDD_REG_NEXT_BYTE   4'h8

// ------------------------------------------------------------
// ProDOS command codes
// ------------------------------------------------------------
`define HDD_CMD_STATUS      8'h00
`define HDD_CMD_READ        8'h01
`define HDD_CMD_WRITE       8'h02

// ------------------------------------------------------------
// ProDOS status codes
// ------------------------------------------------------------
`define HDD_STATUS_OK       8'h00
`define HDD_STATUS_ERROR    8'h01
// Transfer in progress
`define HDD_STATUS_BUSY     8'h80
// Write attempted on a protected unit
`define HDD_STATUS_PROTECT  8'h2B

// Sector geometry, fixed by ProDOS
`define HDD_SECTOR_BYTES    512
`define HDD_SECTOR_AW       9

// Data bus value when no register is being read
`define HDD_BUS_IDLE        8'hFF

`endif
